// ==== design/mem_map_pkg.sv ====
`default_nettype none

package mem_map_pkg;

   localparam int addr_w      = 16;
   localparam int data_w      = 8;
   localparam int num_masters = 4;
   localparam int num_slaves  = 6;
   localparam int cnt_w       = $clog2(num_masters + 1); // Holds a count of 0 to 4.

   typedef logic [addr_w-1:0] addr_t;
   typedef logic [data_w-1:0] data_t;

   // Real regions double as slave indices.
   typedef enum logic [2:0] {
      REGION_NONE      = 3'd7,
      REGION_CARTRIDGE = 3'd0,
      REGION_LCDRAM    = 3'd1,
      REGION_WRAM      = 3'd2,
      REGION_OAM       = 3'd3,
      REGION_IOREG     = 3'd4,
      REGION_LWRAM     = 3'd5
   } region_e;

   // Higher index wins ownership of a slave.
   typedef enum logic [1:0] {
      MASTER_CPU  = 2'd0,
      MASTER_PPU  = 2'd1,
      MASTER_RDMA = 2'd2,
      MASTER_WDMA = 2'd3
   } master_e;

   // Memory map, low bound included and high bound excluded.
   localparam addr_t cartridge_lo = 16'h0000;
   localparam addr_t cartridge_hi = 16'h8000;
   localparam addr_t lcdram_lo    = 16'h8000;
   localparam addr_t lcdram_hi    = 16'hA000;
   localparam addr_t wram_lo      = 16'hC000;
   localparam addr_t wram_hi      = 16'hE000;
   localparam addr_t oam_lo       = 16'hFE00;
   localparam addr_t oam_hi       = 16'hFEA0;
   localparam addr_t ioreg_lo     = 16'hFF00;
   localparam addr_t ioreg_hi     = 16'hFF80;
   localparam addr_t lwram_lo     = 16'hFF80;
   localparam addr_t lwram_hi     = 16'hFFFF; // So 0xFFFF itself maps nowhere.

   typedef struct packed {
      addr_t addr;
      data_t wdata;
      logic  we_l;    // Unused for the read DMA.
      logic  re_l;    // Unused for the write DMA.
   } master_req_t;

   typedef struct packed {
      addr_t addr;
      data_t wdata;
      logic  data_oe; // Write data valid toward the slave.
      logic  we_l;
      logic  re_l;
   } slave_req_t;

   typedef master_req_t [num_masters-1:0] master_req_array_t;
   typedef slave_req_t  [num_slaves-1:0]  slave_req_array_t;
   typedef region_e     [num_masters-1:0] region_array_t;

endpackage

`default_nettype wire

// ==== design/region_decoder.sv ====
`default_nettype none

module region_decoder import mem_map_pkg::*; (
   input  wire addr_t addr,
   output region_e    region
);

   function automatic logic in_range(addr_t a, addr_t lo, addr_t hi);
      return (a >= lo) && (a < hi);
   endfunction

   // Ranges are disjoint, so the order of the checks does not matter.
   always_comb begin
      region = REGION_NONE;
      if (in_range(addr, cartridge_lo, cartridge_hi)) begin
         region = REGION_CARTRIDGE;
      end
      else if (in_range(addr, lcdram_lo, lcdram_hi)) begin
         region = REGION_LCDRAM;
      end
      else if (in_range(addr, wram_lo, wram_hi)) begin
         region = REGION_WRAM;
      end
      else if (in_range(addr, oam_lo, oam_hi)) begin
         region = REGION_OAM;
      end
      else if (in_range(addr, ioreg_lo, ioreg_hi)) begin
         region = REGION_IOREG;
      end
      else if (in_range(addr, lwram_lo, lwram_hi)) begin
         region = REGION_LWRAM;
      end
   end

endmodule

`default_nettype wire

// ==== design/slave_request_router.sv ====
`default_nettype none

module slave_request_router import mem_map_pkg::*; (
   input  wire master_req_array_t master_req,
   input  wire region_array_t     region,
   output slave_req_array_t       slave_req,
   output master_e [num_slaves-1:0] owner,
   output logic [num_slaves-1:0]  owned
);

   master_req_t sel; // Request of the slave's current owner.

   // Ownership goes by decode alone, highest priority master first.
   always_comb begin
      for (int s = 0; s < num_slaves; s++) begin
         owned[s] = 1'b0;
         owner[s] = MASTER_CPU;
         for (int m = num_masters - 1; m >= 0; m--) begin
            if (!owned[s] && region[m] == region_e'(s)) begin
               owned[s] = 1'b1;
               owner[s] = master_e'(m);
            end
         end
      end
   end

   always_comb begin
      sel = '0;
      for (int s = 0; s < num_slaves; s++) begin
         sel = master_req[owner[s]];

         // Idle slave.
         slave_req[s].addr    = '0;
         slave_req[s].wdata   = '0;
         slave_req[s].data_oe = 1'b0;
         slave_req[s].we_l    = 1'b1;
         slave_req[s].re_l    = 1'b1;

         if (owned[s]) begin
            slave_req[s].addr  = sel.addr;
            slave_req[s].wdata = sel.wdata;

            // Write DMA never reads.
            slave_req[s].re_l = (owner[s] == MASTER_WDMA) ? 1'b1 : sel.re_l;

            // Read DMA never writes.
            slave_req[s].we_l = (owner[s] == MASTER_RDMA) ? 1'b1 : sel.we_l;

            slave_req[s].data_oe = (owner[s] != MASTER_RDMA) && !sel.we_l;
         end
      end
   end

endmodule

`default_nettype wire

// ==== design/read_return_router.sv ====
`default_nettype none

module read_return_router import mem_map_pkg::*; (
   input  wire master_req_array_t        master_req,
   input  wire region_array_t            region,
   input  wire master_e [num_slaves-1:0] owner,
   input  wire logic [num_slaves-1:0]    owned,
   input  wire data_t [num_slaves-1:0]   slave_rdata,
   output data_t [num_masters-1:0]       master_rdata,
   output logic [num_masters-1:0]        master_rdata_oe
);

   region_e target; // Slave the current master decodes to.
   logic    serve;

   always_comb begin
      target = REGION_NONE;
      serve  = 1'b0;
      for (int m = 0; m < num_masters; m++) begin
         target = region[m];
         serve  = 1'b0;

         // Only a reading owner gets data; the write DMA has no read path.
         if (target != REGION_NONE && m != int'(MASTER_WDMA)) begin
            serve = owned[target]
                    && owner[target] == master_e'(m)
                    && !master_req[m].re_l;
         end

         if (serve) begin
            master_rdata[m]    = slave_rdata[target];
            master_rdata_oe[m] = 1'b1;
         end
         else begin
            master_rdata[m]    = '0;
            master_rdata_oe[m] = 1'b0;
         end
      end
   end

endmodule

`default_nettype wire

// ==== design/access_conflict_monitor.sv ====
`default_nettype none

module access_conflict_monitor import mem_map_pkg::*; (
   input  wire logic              clk,
   input  wire logic              arst_n,
   input  wire master_req_array_t master_req,
   input  wire region_array_t     region,
   output logic                   same_port_conflict,
   output logic                   conflict_seen
);

   logic [num_masters-1:0] active;
   logic [cnt_w-1:0]       hits [num_slaves]; // Active masters per slave.

   // A master counts only on the strobes it actually has.
   always_comb begin
      active[MASTER_CPU]  = !master_req[MASTER_CPU].we_l || !master_req[MASTER_CPU].re_l;
      active[MASTER_PPU]  = !master_req[MASTER_PPU].we_l || !master_req[MASTER_PPU].re_l;
      active[MASTER_RDMA] = !master_req[MASTER_RDMA].re_l;
      active[MASTER_WDMA] = !master_req[MASTER_WDMA].we_l;
   end

   always_comb begin
      same_port_conflict = 1'b0;
      for (int s = 0; s < num_slaves; s++) begin
         hits[s] = '0;
         for (int m = 0; m < num_masters; m++) begin
            if (active[m] && region[m] == region_e'(s)) begin
               hits[s] = hits[s] + cnt_w'(1);
            end
         end
         if (hits[s] >= cnt_w'(2)) begin
            same_port_conflict = 1'b1;
         end
      end
   end

   // Sticky until reset.
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         conflict_seen <= 1'b0;
      end
      else if (same_port_conflict) begin
         conflict_seen <= 1'b1;
      end
   end

   a_seen_sticky: assert property (@(posedge clk) disable iff (!arst_n)
      conflict_seen |=> conflict_seen);

   a_seen_follows: assert property (@(posedge clk) disable iff (!arst_n)
      same_port_conflict |=> conflict_seen);

   a_idle_no_conflict: assert property (@(posedge clk) disable iff (!arst_n)
      (active == '0) |-> !same_port_conflict);

endmodule

`default_nettype wire

// ==== design/memory_router.sv ====
`default_nettype none

module memory_router import mem_map_pkg::*; (
   input  wire logic                    clk,
   input  wire logic                    arst_n,

   // Master side.
   input  wire master_req_array_t       master_req,
   output data_t [num_masters-1:0]      master_rdata,
   output logic [num_masters-1:0]       master_rdata_oe,

   // Slave side.
   input  wire data_t [num_slaves-1:0]  slave_rdata,
   output slave_req_array_t             slave_req,

   // Same-slave access error, live and sticky.
   output logic                         same_port_conflict,
   output logic                         conflict_seen
);

   wire region_array_t     region;   // One decoded region per master.
   master_e [num_slaves-1:0] owner;
   logic [num_slaves-1:0]  owned;

   region_decoder decode_cpu (
      .addr   (master_req[MASTER_CPU].addr),
      .region (region[MASTER_CPU])
   );

   region_decoder decode_ppu (
      .addr   (master_req[MASTER_PPU].addr),
      .region (region[MASTER_PPU])
   );

   region_decoder decode_rdma (
      .addr   (master_req[MASTER_RDMA].addr),
      .region (region[MASTER_RDMA])
   );

   region_decoder decode_wdma (
      .addr   (master_req[MASTER_WDMA].addr),
      .region (region[MASTER_WDMA])
   );

   slave_request_router u_slave_request_router (
      .master_req (master_req),
      .region     (region),
      .slave_req  (slave_req),
      .owner      (owner),
      .owned      (owned)
   );

   read_return_router u_read_return_router (
      .master_req      (master_req),
      .region          (region),
      .owner           (owner),
      .owned           (owned),
      .slave_rdata     (slave_rdata),
      .master_rdata    (master_rdata),
      .master_rdata_oe (master_rdata_oe)
   );

   access_conflict_monitor u_access_conflict_monitor (
      .clk                (clk),
      .arst_n             (arst_n),
      .master_req         (master_req),
      .region             (region),
      .same_port_conflict (same_port_conflict),
      .conflict_seen      (conflict_seen)
   );

endmodule

`default_nettype wire

// ==== sim/router_model.svh ====
`ifndef ROUTER_MODEL_SVH
`define ROUTER_MODEL_SVH

`default_nettype none

// Slave index that an address maps to, or -1 for a gap.
function automatic int decode_addr(addr_t a);
   if (a < 16'h8000) return 0;
   if (a >= 16'h8000 && a < 16'hA000) return 1;
   if (a >= 16'hC000 && a < 16'hE000) return 2;
   if (a >= 16'hFE00 && a < 16'hFEA0) return 3;
   if (a >= 16'hFF00 && a < 16'hFF80) return 4;
   if (a >= 16'hFF80 && a < 16'hFFFF) return 5;
   return -1; // Includes 0xFFFF.
endfunction

// Masters 0 to 3 are CPU, PPU, read DMA and write DMA.
function automatic logic is_active(int m, master_req_t r);
   case (m)
      2:       return !r.re_l;
      3:       return !r.we_l;
      default: return !r.re_l || !r.we_l;
   endcase
endfunction

// Highest master that decodes to the slave, strobes play no part.
function automatic int find_owner(int s, master_req_array_t req);
   for (int m = 3; m >= 0; m--) begin
      if (decode_addr(req[m].addr) == s) return m;
   end
   return -1;
endfunction

function automatic slave_req_t expect_slave(int s, master_req_array_t req);
   slave_req_t e;
   int         o;
   e      = '0;
   e.we_l = 1'b1;
   e.re_l = 1'b1;
   o      = find_owner(s, req);
   if (o >= 0) begin
      e.addr    = req[o].addr;
      e.wdata   = req[o].wdata;
      e.re_l    = (o == 3) ? 1'b1 : req[o].re_l;
      e.we_l    = (o == 2) ? 1'b1 : req[o].we_l;
      e.data_oe = (o != 2) && !req[o].we_l;
   end
   return e;
endfunction

function automatic logic expect_rdata_oe(int m, master_req_array_t req);
   int s;
   s = decode_addr(req[m].addr);
   if (m == 3 || s < 0) return 1'b0; // Write DMA has no read path.
   return (find_owner(s, req) == m) && !req[m].re_l;
endfunction

function automatic data_t expect_rdata(int m, master_req_array_t req,
                                       data_t [num_slaves-1:0] rdata);
   if (!expect_rdata_oe(m, req)) return '0;
   return rdata[decode_addr(req[m].addr)];
endfunction

function automatic logic expect_conflict(master_req_array_t req);
   int hits [6];
   int s;
   for (int i = 0; i < 6; i++) hits[i] = 0;
   for (int m = 0; m < 4; m++) begin
      s = decode_addr(req[m].addr);
      if (s >= 0 && is_active(m, req[m])) hits[s]++;
   end
   for (int i = 0; i < 6; i++) begin
      if (hits[i] >= 2) return 1'b1;
   end
   return 1'b0;
endfunction

`default_nettype wire

`endif

// ==== sim/memory_router_tb.sv ====
`default_nettype none

module memory_router_tb import mem_map_pkg::*; ();

   logic                    clk;
   logic                    arst_n;
   master_req_array_t       master_req;
   data_t [num_slaves-1:0]  slave_rdata;
   slave_req_array_t        slave_req;
   data_t [num_masters-1:0] master_rdata;
   logic [num_masters-1:0]  master_rdata_oe;
   logic                    same_port_conflict;
   logic                    conflict_seen;

   int errors;
   int test_start;
   int tests_run;
   int tests_failed;

   `include "router_model.svh"

   memory_router dut0 (
      .clk                (clk),
      .arst_n             (arst_n),
      .master_req         (master_req),
      .master_rdata       (master_rdata),
      .master_rdata_oe    (master_rdata_oe),
      .slave_rdata        (slave_rdata),
      .slave_req          (slave_req),
      .same_port_conflict (same_port_conflict),
      .conflict_seen      (conflict_seen)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // Region bounds and their neighbours.
   function automatic addr_t edge_addr(int i);
      case (i)
         0:  return 16'h0000;
         1:  return 16'h7FFF;
         2:  return 16'h8000;
         3:  return 16'h9FFF;
         4:  return 16'hA000;
         5:  return 16'hBFFF;
         6:  return 16'hC000;
         7:  return 16'hDFFF;
         8:  return 16'hE000;
         9:  return 16'hFDFF;
         10: return 16'hFE00;
         11: return 16'hFE9F;
         12: return 16'hFEA0;
         13: return 16'hFEFF;
         14: return 16'hFF00;
         15: return 16'hFF7F;
         16: return 16'hFF80;
         17: return 16'hFFFE;
         default: return 16'hFFFF;
      endcase
   endfunction

   function automatic addr_t region_addr(int s);
      case (s)
         0: return addr_t'($urandom % 32'h8000);
         1: return 16'h8000 + addr_t'($urandom % 32'h2000);
         2: return 16'hC000 + addr_t'($urandom % 32'h2000);
         3: return 16'hFE00 + addr_t'($urandom % 32'hA0);
         4: return 16'hFF00 + addr_t'($urandom % 32'h80);
         default: return 16'hFF80 + addr_t'($urandom % 32'h7F);
      endcase
   endfunction

   function automatic addr_t gap_addr();
      case ($urandom % 4)
         0: return 16'hA000 + addr_t'($urandom % 32'h2000);
         1: return 16'hE000 + addr_t'($urandom % 32'h1E00);
         2: return 16'hFEA0 + addr_t'($urandom % 32'h60);
         default: return 16'hFFFF;
      endcase
   endfunction

   function automatic addr_t pick_addr();
      case ($urandom % 4)
         0: return addr_t'($urandom);
         1: return edge_addr($urandom % 19);
         default: return region_addr($urandom % 6);
      endcase
   endfunction

   // Idle masters sit at 0xFFFF so they own nothing.
   task automatic idle_masters();
      for (int m = 0; m < num_masters; m++) begin
         master_req[m].addr  = 16'hFFFF;
         master_req[m].wdata = '0;
         master_req[m].we_l  = 1'b1;
         master_req[m].re_l  = 1'b1;
      end
   endtask

   task automatic random_master(int m, addr_t a);
      master_req[m].addr  = a;
      master_req[m].wdata = data_t'($urandom);
      master_req[m].we_l  = ($urandom % 2) == 0;
      master_req[m].re_l  = ($urandom % 2) == 0;
   endtask

   task automatic random_rdata();
      for (int s = 0; s < num_slaves; s++) slave_rdata[s] = data_t'($urandom);
   endtask

   task automatic check_outputs();
      slave_req_t exp_s;
      data_t      exp_d;
      logic       exp_oe;
      logic       exp_c;
      for (int s = 0; s < num_slaves; s++) begin
         exp_s = expect_slave(s, master_req);
         if (slave_req[s] !== exp_s) begin
            $display("[FAIL] slave_req[%0d] expected %h got %h", s, exp_s, slave_req[s]);
            errors++;
         end
      end
      for (int m = 0; m < num_masters; m++) begin
         exp_d  = expect_rdata(m, master_req, slave_rdata);
         exp_oe = expect_rdata_oe(m, master_req);
         if (master_rdata[m] !== exp_d) begin
            $display("[FAIL] master_rdata[%0d] expected %h got %h", m, exp_d, master_rdata[m]);
            errors++;
         end
         if (master_rdata_oe[m] !== exp_oe) begin
            $display("[FAIL] master_rdata_oe[%0d] expected %h got %h", m, exp_oe,
                     master_rdata_oe[m]);
            errors++;
         end
      end
      exp_c = expect_conflict(master_req);
      if (same_port_conflict !== exp_c) begin
         $display("[FAIL] same_port_conflict expected %h got %h", exp_c, same_port_conflict);
         errors++;
      end
   endtask

   task automatic check_seen(logic exp);
      if (conflict_seen !== exp) begin
         $display("[FAIL] conflict_seen expected %h got %h", exp, conflict_seen);
         errors++;
      end
   endtask

   task automatic pulse_reset();
      @(negedge clk);
      arst_n = 1'b0;
      idle_masters();
      repeat (2) @(negedge clk);
      arst_n = 1'b1;
   endtask

   task automatic begin_test();
      test_start = errors;
   endtask

   task automatic end_test(string name);
      tests_run++;
      if (errors != test_start) tests_failed++;
      $display("test %s finished with %0d errors", name, errors - test_start);
   endtask

   task automatic run_decode_forward();
      int m;
      begin_test();
      repeat (200) begin
         @(negedge clk);
         idle_masters();
         random_rdata();
         m = $urandom % num_masters;
         random_master(m, pick_addr());
         if (m == 2) master_req[m].re_l = 1'b0;
         else if (m == 3) master_req[m].we_l = 1'b0;
         else if (master_req[m].we_l && master_req[m].re_l) master_req[m].re_l = 1'b0;
         #1 check_outputs();
      end
      end_test("decode_forward");
   endtask

   task automatic run_priority();
      int s;
      begin_test();
      repeat (200) begin
         @(negedge clk);
         random_rdata();
         s = $urandom % num_slaves;
         for (int m = 0; m < num_masters; m++) begin
            random_master(m, ($urandom % 4 != 0) ? region_addr(s) : pick_addr());
         end
         #1 check_outputs();
      end
      end_test("priority");
   endtask

   task automatic run_read_return();
      begin_test();
      repeat (200) begin
         @(negedge clk);
         random_rdata();
         for (int m = 0; m < num_masters; m++) begin
            random_master(m, ($urandom % 2) ? region_addr($urandom % 3) : pick_addr());
            master_req[m].re_l = ($urandom % 4) == 0; // Mostly reading.
         end
         #1 check_outputs();
      end
      end_test("read_return");
   endtask

   task automatic run_unmapped();
      begin_test();
      repeat (100) begin
         @(negedge clk);
         random_rdata();
         for (int m = 0; m < num_masters; m++) random_master(m, gap_addr());
         #1 check_outputs();
         if (master_rdata_oe !== '0) begin
            $display("a master got read data from an unmapped address");
            errors++;
         end
      end
      end_test("unmapped");
   endtask

   task automatic run_conflict();
      int s;
      begin_test();
      pulse_reset();
      #1 check_seen(1'b0);
      repeat (10) begin
         @(negedge clk);
         idle_masters();
         random_master(0, pick_addr());
         #1 check_outputs();
         @(posedge clk);
         #1 check_seen(1'b0);
      end
      // CPU and PPU read the same slave.
      @(negedge clk);
      s = $urandom % num_slaves;
      idle_masters();
      master_req[0].addr = region_addr(s);
      master_req[0].re_l = 1'b0;
      master_req[1].addr = region_addr(s);
      master_req[1].re_l = 1'b0;
      #1 check_outputs();
      check_seen(1'b0);
      @(posedge clk);
      #1 check_seen(1'b1);
      repeat (50) begin
         @(negedge clk);
         random_rdata();
         for (int m = 0; m < num_masters; m++) random_master(m, pick_addr());
         #1 check_outputs();
         @(posedge clk);
         #1 check_seen(1'b1);
      end
      pulse_reset();
      #1 check_seen(1'b0);
      end_test("conflict");
   endtask

   initial begin : watchdog
      for (int i = 0; i < 20000; i++) @(posedge clk);
      $display("timeout: the run did not finish within 20000 cycles");
      $display("FAIL: see errors above");
      $finish;
   end

   initial begin
      void'($urandom(32'h808a));
      errors       = 0;
      test_start   = 0;
      tests_run    = 0;
      tests_failed = 0;
      arst_n       = 1'b0;
      idle_masters();
      slave_rdata  = '0;
      repeat (2) @(posedge clk);
      @(negedge clk);
      arst_n = 1'b1;

      run_decode_forward();
      run_priority();
      run_read_return();
      run_unmapped();
      run_conflict();

      $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
      if (errors == 0) begin
         $display("PASS: all tests");
      end
      else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+sim
design/mem_map_pkg.sv
design/region_decoder.sv
design/slave_request_router.sv
design/read_return_router.sv
design/access_conflict_monitor.sv
design/memory_router.sv
sim/memory_router_tb.sv

// ==== Bender.yml ====
package:
  name: memory_router

sources:
  - design/mem_map_pkg.sv
  - design/region_decoder.sv
  - design/slave_request_router.sv
  - design/read_return_router.sv
  - design/access_conflict_monitor.sv
  - design/memory_router.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/memory_router_tb.sv
